/* arcade_input_settings.svh */
// Arcade input settings
`ifndef ARCADE_INPUT_SETTINGS_SVH
`define ARCADE_INPUT_SETTINGS_SVH

// PS/2 set 2 scan codes for the mapped keys
`define KEY_START1          8'h16
`define KEY_START2          8'h1E
`define KEY_COIN1           8'h2E
`define KEY_COIN2           8'h36
`define KEY_PAUSE           8'h4D
`define KEY_UP              8'h75
`define KEY_DOWN            8'h72
`define KEY_LEFT            8'h6B
`define KEY_RIGHT           8'h74
// Ctrl, alt, space, shift
`define KEY_FIRE_A          8'h14
`define KEY_FIRE_B          8'h11
`define KEY_FIRE_X          8'h29
`define KEY_FIRE_Y          8'h12

// Bit positions in the host joystick word
`define JOY_RIGHT_BIT       0
`define JOY_LEFT_BIT        1
`define JOY_DOWN_BIT        2
`define JOY_UP_BIT          3
`define JOY_FIRE_A_BIT      4
`define JOY_FIRE_B_BIT      5
`define JOY_FIRE_X_BIT      6
`define JOY_FIRE_Y_BIT      7
`define JOY_START1_BIT      8
`define JOY_COIN1_BIT       9
`define JOY_START2_BIT      10
`define JOY_PAUSE_BIT       11

// DIP switch storage and the download slot that fills it
`define DIP_BYTES           8
`define DIP_BANKS_USED      3
`define DIP_DOWNLOAD_INDEX  8'd254
`define DOWNLOAD_ADDR_WIDTH 25

`endif

/* arcade_input_pkg.sv */
// Arcade input types
`include "arcade_input_settings.svh"

package arcade_input_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Host side
    ////////////////////////////////////////////////////////////////////////////

    // One keyboard event as delivered by the host
    typedef struct packed {
        logic       toggle;     // Flips once per new event
        logic       pressed;    // 1 on make, 0 on break
        logic       extended;   // E0 prefixed code
        logic [7:0] code;
    } ps2_key_t;

    // Raw joystick word, see JOY_*_BIT for the layout
    typedef logic [15:0] joystick_t;

    // Download stream write, strobe valid for one clock
    typedef struct packed {
        logic                            wr;
        logic [7:0]                      index;
        logic [`DOWNLOAD_ADDR_WIDTH-1:0] addr;
        logic [7:0]                      data;
    } download_t;

    ////////////////////////////////////////////////////////////////////////////
    // Internal
    ////////////////////////////////////////////////////////////////////////////

    // Held keyboard buttons, active high
    typedef struct packed {
        logic start1;
        logic start2;
        logic coin1;
        logic coin2;
        logic pause;
        logic up;
        logic down;
        logic left;
        logic right;
        logic a;
        logic b;
        logic x;
        logic y;
    } kbd_buttons_t;

    ////////////////////////////////////////////////////////////////////////////
    // Board side
    ////////////////////////////////////////////////////////////////////////////

    // One player's controls, active low
    typedef struct packed {
        logic [3:0] joystick;   // {up, down, left, right}
        logic [3:0] buttons;    // {a, b, x, y}
    } player_inputs_t;

    // Everything the arcade board reads from the control panel
    typedef struct packed {
        logic [1:0]     coin;       // {coin2, coin1}, active low
        logic [1:0]     start;      // {start2, start1}, active low
        player_inputs_t p1;
        player_inputs_t p2;
        logic           pause_req;  // Active high
    } arcade_inputs_t;

    // Inverted DIP bytes handed to the board, byte 2 on top
    typedef logic [`DIP_BANKS_USED-1:0][7:0] dip_banks_t;

endpackage

/* ps2_button_decoder.sv */
// PS/2 keyboard button decoder
`timescale 1ns/1ps
`include "arcade_input_settings.svh"

module ps2_button_decoder
    import arcade_input_pkg::*;
(
    input  logic         clk_sys,
    input  logic         reset,
    input  ps2_key_t     ps2_key,
    output kbd_buttons_t buttons
);

    ////////////////////////////////////////////////////////////////////////////
    // Event detection
    ////////////////////////////////////////////////////////////////////////////

    // Host flips the toggle bit for every new key event
    logic toggle_prev;
    logic key_event;

    assign key_event = ps2_key.toggle != toggle_prev;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            toggle_prev <= 1'b0;
        end else begin
            toggle_prev <= ps2_key.toggle;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Held button levels
    ////////////////////////////////////////////////////////////////////////////

    // Make sets the level, break clears it
    // Unmapped codes fall through and leave every button alone
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            buttons <= '0;
        end else if (key_event) begin
            case (ps2_key.code)
                // Cabinet buttons
                `KEY_START1: begin
                    buttons.start1 <= ps2_key.pressed;
                end
                `KEY_START2: begin
                    buttons.start2 <= ps2_key.pressed;
                end
                `KEY_COIN1: begin
                    buttons.coin1 <= ps2_key.pressed;
                end
                `KEY_COIN2: begin
                    buttons.coin2 <= ps2_key.pressed;
                end
                `KEY_PAUSE: begin
                    buttons.pause <= ps2_key.pressed;
                end

                // Directions, shared by both players
                `KEY_UP: begin
                    buttons.up <= ps2_key.pressed;
                end
                `KEY_DOWN: begin
                    buttons.down <= ps2_key.pressed;
                end
                `KEY_LEFT: begin
                    buttons.left <= ps2_key.pressed;
                end
                `KEY_RIGHT: begin
                    buttons.right <= ps2_key.pressed;
                end

                // Fire buttons, also shared
                `KEY_FIRE_A: begin
                    buttons.a <= ps2_key.pressed;
                end
                `KEY_FIRE_B: begin
                    buttons.b <= ps2_key.pressed;
                end
                `KEY_FIRE_X: begin
                    buttons.x <= ps2_key.pressed;
                end
                `KEY_FIRE_Y: begin
                    buttons.y <= ps2_key.pressed;
                end

                default: begin
                end
            endcase
        end
    end

endmodule

/* dip_switch_bank.sv */
// DIP switch bank
`timescale 1ns/1ps
`include "arcade_input_settings.svh"

module dip_switch_bank
    import arcade_input_pkg::*;
(
    input  logic       clk_sys,
    input  logic       reset,
    input  download_t  download,
    output dip_banks_t dip_banks
);

    // Low address bits pick one of the stored bytes
    localparam int SEL_W = $clog2(`DIP_BYTES);

    logic [7:0] dip_sw [`DIP_BYTES];
    logic       dip_write;

    // Only the DIP slot, and only addresses inside the bank
    assign dip_write = download.wr
                    && (download.index == `DIP_DOWNLOAD_INDEX)
                    && (download.addr[`DOWNLOAD_ADDR_WIDTH-1:SEL_W] == '0);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            for (int i = 0; i < `DIP_BYTES; i++) begin
                dip_sw[i] <= 8'h00;
            end
        end else if (dip_write) begin
            dip_sw[download.addr[SEL_W-1:0]] <= download.data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Board view
    ////////////////////////////////////////////////////////////////////////////

    // Board switches are active low, so a stored 0 reads as off
    always_comb begin
        for (int i = 0; i < `DIP_BANKS_USED; i++) begin
            dip_banks[i] = ~dip_sw[i];
        end
    end

endmodule

/* control_input_map.sv */
// Control panel input mapper
`timescale 1ns/1ps
`include "arcade_input_settings.svh"

module control_input_map
    import arcade_input_pkg::*;
(
    input  kbd_buttons_t   buttons,
    input  joystick_t      joystick_0,
    input  joystick_t      joystick_1,
    output arcade_inputs_t arcade_inputs
);

    // One player's panel, keyboard ORed with that player's stick, then inverted
    function automatic player_inputs_t map_player(
        input kbd_buttons_t kbd,
        input joystick_t    joy
    );
        player_inputs_t p;

        p.joystick = ~{
            kbd.up    | joy[`JOY_UP_BIT],
            kbd.down  | joy[`JOY_DOWN_BIT],
            kbd.left  | joy[`JOY_LEFT_BIT],
            kbd.right | joy[`JOY_RIGHT_BIT]
        };
        p.buttons = ~{
            kbd.a | joy[`JOY_FIRE_A_BIT],
            kbd.b | joy[`JOY_FIRE_B_BIT],
            kbd.x | joy[`JOY_FIRE_X_BIT],
            kbd.y | joy[`JOY_FIRE_Y_BIT]
        };
        return p;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Cabinet buttons
    ////////////////////////////////////////////////////////////////////////////

    // Either stick may insert coin 1, start a game or pause
    joystick_t joy_any;
    logic      start1_req;
    logic      start2_req;
    logic      coin1_req;
    logic      coin2_req;

    assign joy_any    = joystick_0 | joystick_1;
    assign start1_req = buttons.start1 | joy_any[`JOY_START1_BIT];
    assign start2_req = buttons.start2 | joy_any[`JOY_START2_BIT];
    assign coin1_req  = buttons.coin1  | joy_any[`JOY_COIN1_BIT];
    // No stick bit for the second coin slot
    assign coin2_req  = buttons.coin2;

    ////////////////////////////////////////////////////////////////////////////
    // Board inputs
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        arcade_inputs.coin      = ~{coin2_req, coin1_req};
        arcade_inputs.start     = ~{start2_req, start1_req};
        arcade_inputs.p1        = map_player(buttons, joystick_0);
        arcade_inputs.p2        = map_player(buttons, joystick_1);
        // Pause goes to the pause control, which wants it active high
        arcade_inputs.pause_req = buttons.pause | joy_any[`JOY_PAUSE_BIT];
    end

endmodule

/* arcade_input_top.sv */
// Arcade input front end
`timescale 1ns/1ps

module arcade_input_top
    import arcade_input_pkg::*;
(
    input  logic           clk_sys,
    input  logic           reset,
    input  ps2_key_t       ps2_key,
    input  joystick_t      joystick_0,
    input  joystick_t      joystick_1,
    input  download_t      download,
    output arcade_inputs_t arcade_inputs,
    output dip_banks_t     dip_banks
);

    kbd_buttons_t kbd_buttons;

    ////////////////////////////////////////////////////////////////////////////
    // Keyboard
    ////////////////////////////////////////////////////////////////////////////

    ps2_button_decoder ps2_button_decoder_inst (
        .clk_sys (clk_sys),
        .reset   (reset),
        .ps2_key (ps2_key),
        .buttons (kbd_buttons)
    );

    // DIP bytes come in through the download stream
    dip_switch_bank dip_switch_bank_inst (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .download  (download),
        .dip_banks (dip_banks)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Board inputs
    ////////////////////////////////////////////////////////////////////////////

    control_input_map control_input_map_inst (
        .buttons       (kbd_buttons),
        .joystick_0    (joystick_0),
        .joystick_1    (joystick_1),
        .arcade_inputs (arcade_inputs)
    );

endmodule

/* tb_arcade_input.sv */
// Arcade input testbench
`timescale 1ns/1ps
`include "arcade_input_settings.svh"

module tb_arcade_input
    import arcade_input_pkg::*;
();

    localparam int RESET_CYCLES  = 5;
    localparam int RESET_TIMEOUT = 50;
    localparam download_t NO_WRITE = '0;

    // One table row, stimulus first, expected outputs filled in by the model
    typedef struct packed {
        ps2_key_t       key;
        joystick_t      joy0;
        joystick_t      joy1;
        download_t      dl;
        arcade_inputs_t exp_inputs;
        dip_banks_t     exp_dips;
    } table_row_t;

    logic           clk_sys;
    logic           reset;
    ps2_key_t       ps2_key;
    joystick_t      joystick_0;
    joystick_t      joystick_1;
    download_t      download;
    arcade_inputs_t arcade_inputs;
    dip_banks_t     dip_banks;

    table_row_t rows [$];
    logic       cur_toggle;
    logic [31:0] lfsr_state;
    int         wait_cycles;

    logic [7:0] key_codes [13] = '{
        `KEY_START1, `KEY_START2, `KEY_COIN1, `KEY_COIN2, `KEY_PAUSE,
        `KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT,
        `KEY_FIRE_A, `KEY_FIRE_B, `KEY_FIRE_X, `KEY_FIRE_Y
    };

    arcade_input_top arcade_input_top_inst (
        .clk_sys       (clk_sys),
        .reset         (reset),
        .ps2_key       (ps2_key),
        .joystick_0    (joystick_0),
        .joystick_1    (joystick_1),
        .download      (download),
        .arcade_inputs (arcade_inputs),
        .dip_banks     (dip_banks)
    );

    always #5 clk_sys = ~clk_sys;

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        reset <= 1'b0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random source
    ////////////////////////////////////////////////////////////////////////////

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic random_word(output joystick_t w);
        for (int b = 0; b < 16; b++) begin
            w[b] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Bit of kbd_buttons_t a scan code drives, -1 when unmapped
    function automatic int button_index(input logic [7:0] code);
        case (code)
            `KEY_START1: return 12;
            `KEY_START2: return 11;
            `KEY_COIN1:  return 10;
            `KEY_COIN2:  return 9;
            `KEY_PAUSE:  return 8;
            `KEY_UP:     return 7;
            `KEY_DOWN:   return 6;
            `KEY_LEFT:   return 5;
            `KEY_RIGHT:  return 4;
            `KEY_FIRE_A: return 3;
            `KEY_FIRE_B: return 2;
            `KEY_FIRE_X: return 1;
            `KEY_FIRE_Y: return 0;
            default:     return -1;
        endcase
    endfunction

    function automatic player_inputs_t model_player(input kbd_buttons_t kb, input joystick_t j);
        logic [3:0] dir_on;
        logic [3:0] fire_on;
        player_inputs_t p;

        dir_on[3]  = kb.up    | j[`JOY_UP_BIT];
        dir_on[2]  = kb.down  | j[`JOY_DOWN_BIT];
        dir_on[1]  = kb.left  | j[`JOY_LEFT_BIT];
        dir_on[0]  = kb.right | j[`JOY_RIGHT_BIT];
        fire_on[3] = kb.a | j[`JOY_FIRE_A_BIT];
        fire_on[2] = kb.b | j[`JOY_FIRE_B_BIT];
        fire_on[1] = kb.x | j[`JOY_FIRE_X_BIT];
        fire_on[0] = kb.y | j[`JOY_FIRE_Y_BIT];
        p.joystick = ~dir_on;
        p.buttons  = ~fire_on;
        return p;
    endfunction

    function automatic arcade_inputs_t model_inputs(
        input kbd_buttons_t kb,
        input joystick_t    j0,
        input joystick_t    j1
    );
        logic [1:0] coin_on;
        logic [1:0] start_on;
        arcade_inputs_t r;

        coin_on[0]  = kb.coin1 | j0[`JOY_COIN1_BIT] | j1[`JOY_COIN1_BIT];
        // Second coin slot has no stick bit
        coin_on[1]  = kb.coin2;
        start_on[0] = kb.start1 | j0[`JOY_START1_BIT] | j1[`JOY_START1_BIT];
        start_on[1] = kb.start2 | j0[`JOY_START2_BIT] | j1[`JOY_START2_BIT];
        r.coin      = ~coin_on;
        r.start     = ~start_on;
        r.p1        = model_player(kb, j0);
        r.p2        = model_player(kb, j1);
        r.pause_req = kb.pause | j0[`JOY_PAUSE_BIT] | j1[`JOY_PAUSE_BIT];
        return r;
    endfunction

    // Walk the table in order and fill in what each row should produce
    task automatic fill_expected();
        kbd_buttons_t kb;
        logic         prev;
        logic [7:0]   dip [`DIP_BYTES];
        int           idx;
        dip_banks_t   d;
        table_row_t   row;

        kb   = '0;
        prev = 1'b0;
        for (int i = 0; i < `DIP_BYTES; i++) begin
            dip[i] = 8'h00;
        end
        for (int r = 0; r < rows.size(); r++) begin
            row = rows[r];
            if (row.key.toggle != prev) begin
                idx = button_index(row.key.code);
                if (idx >= 0) begin
                    kb[idx] = row.key.pressed;
                end
            end
            prev = row.key.toggle;
            if (row.dl.wr && row.dl.index == `DIP_DOWNLOAD_INDEX && row.dl.addr < 25'd8) begin
                dip[row.dl.addr[2:0]] = row.dl.data;
            end
            row.exp_inputs = model_inputs(kb, row.joy0, row.joy1);
            for (int i = 0; i < `DIP_BANKS_USED; i++) begin
                d[i] = ~dip[i];
            end
            row.exp_dips = d;
            rows[r] = row;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Table construction
    ////////////////////////////////////////////////////////////////////////////

    task automatic add_row(input ps2_key_t key, input joystick_t j0, input joystick_t j1,
                           input download_t dl);
        table_row_t row;

        row      = '0;
        row.key  = key;
        row.joy0 = j0;
        row.joy1 = j1;
        row.dl   = dl;
        rows.push_back(row);
    endtask

    // Key word that is not an event
    function automatic ps2_key_t held_key(input logic [7:0] code, input logic pressed);
        ps2_key_t k;

        k.toggle   = cur_toggle;
        k.pressed  = pressed;
        k.extended = 1'b0;
        k.code     = code;
        return k;
    endfunction

    task automatic add_key(input logic [7:0] code, input logic pressed);
        cur_toggle = ~cur_toggle;
        add_row(held_key(code, pressed), '0, '0, NO_WRITE);
    endtask

    task automatic add_random_rows(input int count);
        joystick_t j0;
        joystick_t j1;

        for (int n = 0; n < count; n++) begin
            random_word(j0);
            random_word(j1);
            add_row(held_key(8'h00, 1'b0), j0, j1, NO_WRITE);
        end
    endtask

    task automatic add_dip_write(input logic [7:0] index, input logic [24:0] addr,
                                 input logic [7:0] data);
        download_t dl;

        dl.wr    = 1'b1;
        dl.index = index;
        dl.addr  = addr;
        dl.data  = data;
        add_row(held_key(8'h00, 1'b0), '0, '0, dl);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_inputs(input arcade_inputs_t actual, input arcade_inputs_t expected,
                                input int row);
        if (actual !== expected) begin
            $display("error at %0t: row %0d arcade_inputs is %h, expected %h",
                     $time, row, actual, expected);
            $display("Test failed");
            $fatal(1, "arcade_inputs mismatch");
        end
    endtask

    task automatic check_dips(input dip_banks_t actual, input dip_banks_t expected,
                              input int row);
        if (actual !== expected) begin
            $display("error at %0t: row %0d dip_banks is %h, expected %h",
                     $time, row, actual, expected);
            $display("Test failed");
            $fatal(1, "dip_banks mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk_sys      = 1'b0;
        ps2_key      = '0;
        joystick_0   = '0;
        joystick_1   = '0;
        download     = '0;
        cur_toggle   = 1'b0;
        lfsr_state   = 32'h855f_9932;
        wait_cycles  = 0;

        // Idle row shows the reset state
        add_row(held_key(8'h00, 1'b0), '0, '0, NO_WRITE);
        for (int k = 0; k < 13; k++) begin
            add_key(key_codes[k], 1'b1);
            add_key(key_codes[k], 1'b0);
        end

        // Unmapped code and stale toggle while up is held
        add_key(`KEY_UP, 1'b1);
        add_key(8'h55, 1'b1);
        add_row(held_key(`KEY_START1, 1'b1), '0, '0, NO_WRITE);
        add_row(held_key(`KEY_COIN2, 1'b1), '0, '0, NO_WRITE);
        add_key(`KEY_UP, 1'b0);

        // Sticks with and without held keys
        add_key(`KEY_FIRE_A, 1'b1);
        add_key(`KEY_COIN2, 1'b1);
        add_random_rows(24);
        add_key(`KEY_FIRE_A, 1'b0);
        add_key(`KEY_COIN2, 1'b0);
        add_random_rows(12);

        add_dip_write(`DIP_DOWNLOAD_INDEX, 25'd0, 8'h5a);
        add_dip_write(`DIP_DOWNLOAD_INDEX, 25'd1, 8'hc3);
        add_dip_write(`DIP_DOWNLOAD_INDEX, 25'd2, 8'h0f);
        add_dip_write(8'd253, 25'd0, 8'hff);
        add_dip_write(`DIP_DOWNLOAD_INDEX, 25'd8, 8'hff);
        add_dip_write(`DIP_DOWNLOAD_INDEX, 25'h100_0001, 8'hff);
        add_dip_write(`DIP_DOWNLOAD_INDEX, 25'd3, 8'h77);
        add_dip_write(`DIP_DOWNLOAD_INDEX, 25'd0, 8'h00);

        fill_expected();

        do begin
            @(negedge clk_sys);
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) begin
                $display("Reset was still asserted after %0d cycles", RESET_TIMEOUT);
                $display("Test failed");
                $fatal(1, "reset release timeout");
            end
        end while (reset);

        // Each row is held for two edges, the write strobe for one
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk_sys);
            ps2_key    <= rows[i].key;
            joystick_0 <= rows[i].joy0;
            joystick_1 <= rows[i].joy1;
            download   <= rows[i].dl;
            @(posedge clk_sys);
            download.wr <= 1'b0;
            @(negedge clk_sys);
            check_inputs(arcade_inputs, rows[i].exp_inputs, i);
            check_dips(dip_banks, rows[i].exp_dips, i);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* src.f */
+incdir+.
arcade_input_pkg.sv
ps2_button_decoder.sv
dip_switch_bank.sv
control_input_map.sv
arcade_input_top.sv
tb_arcade_input.sv

/* Makefile */
# Verilator simulation of the arcade input front end

VERILATOR ?= verilator
TOP       ?= tb_arcade_input
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing -sv

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv *.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
